/* design/cpu_data_mux.sv */
// Byte returned to the CPU on a read cycle.
// Memory data, the ULA byte or the Kempston byte, FF for any other port
// and for interrupt acknowledge.

`timescale 1ns/1ps

module cpu_data_mux (
	input  zx_bus_pkg::cpu_bus_t bus,
	input  zx_bus_pkg::data_t    mem_rdata,
	input  zx_bus_pkg::data_t    fe_rdata,
	input  zx_bus_pkg::data_t    kempston_data,
	output zx_bus_pkg::data_t    cpu_din
);

	logic mem_rd;
	logic io_rd;

	assign mem_rd = bus.mreq & bus.rd;

	// M1 with IORQ is an interrupt acknowledge, not a port read
	assign io_rd = bus.iorq & bus.rd & ~bus.m1;

	always_comb begin
		if (mem_rd)
			cpu_din = mem_rdata;
		else if (io_rd && !bus.addr[0])
			cpu_din = fe_rdata;
		else if (io_rd && bus.addr[7:0] == 8'h1F)
			cpu_din = kempston_data;
		else
			cpu_din = 8'hFF;
	end

endmodule

/* design/joystick_mapper.sv */
// Joystick handling for the three supported modes.
// Kempston presents both sticks on port 1F, Sinclair and cursor modes
// pull key bits low in the half-row that the CPU address selects.

`timescale 1ns/1ps

module joystick_mapper (
	input  zx_bus_pkg::addr_t      addr,
	input  zx_bus_pkg::joy_state_t joy0,
	input  zx_bus_pkg::joy_state_t joy1,
	input  zx_bus_pkg::joy_mode_t  joy_mode,
	output zx_bus_pkg::key_row_t   joy_mask,
	output zx_bus_pkg::data_t      kempston_data
);

	zx_bus_pkg::joy_state_t joy_any;
	zx_bus_pkg::key_row_t   row_60;
	zx_bus_pkg::key_row_t   row_15;
	logic                   sinclair;
	logic                   cursor;

	assign joy_any  = joy0 | joy1;
	assign sinclair = (joy_mode == zx_bus_pkg::JOY_SINCLAIR);
	assign cursor   = (joy_mode == zx_bus_pkg::JOY_CURSOR);

	assign kempston_data = (joy_mode == zx_bus_pkg::JOY_KEMPSTON) ? {2'b00, joy_any} : '0;

	// ========================================
	// Key row presses, 1 = key held
	// ========================================

	always_comb begin
		row_60 = '0;
		row_15 = '0;
		if (sinclair) begin
			// Stick 0 on keys 6-0
			row_60 = {joy0[zx_bus_pkg::JOY_LEFT], joy0[zx_bus_pkg::JOY_RIGHT],
				joy0[zx_bus_pkg::JOY_DOWN], joy0[zx_bus_pkg::JOY_UP],
				joy0[zx_bus_pkg::JOY_FIRE]};
			// Stick 1 on keys 1-5
			row_15 = {joy1[zx_bus_pkg::JOY_FIRE], joy1[zx_bus_pkg::JOY_UP],
				joy1[zx_bus_pkg::JOY_DOWN], joy1[zx_bus_pkg::JOY_RIGHT],
				joy1[zx_bus_pkg::JOY_LEFT]};
		end else if (cursor) begin
			// Keys 5 to 8 plus 0 for fire, both sticks merged
			row_60 = {joy_any[zx_bus_pkg::JOY_DOWN], joy_any[zx_bus_pkg::JOY_UP],
				joy_any[zx_bus_pkg::JOY_RIGHT], 1'b0, joy_any[zx_bus_pkg::JOY_FIRE]};
			row_15 = {joy_any[zx_bus_pkg::JOY_LEFT], 4'b0000};
		end
	end

	// A12 low scans 6-0, A11 low scans 1-5
	assign joy_mask = ({5{addr[12]}} | ~row_60) & ({5{addr[11]}} | ~row_15);

endmodule

/* design/memory_pager.sv */
// Paging registers 7FFD and 1FFD and the CPU to bank address map.
// The model is captured while reset is high; 48K never unlocks paging.
// Register writes land one cycle after the I/O write condition rises.
// The address map itself is combinational.

`timescale 1ns/1ps

module memory_pager (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t bus,
	input  zx_mem_pkg::model_t   model,
	output zx_mem_pkg::mem_req_t mem_req,
	output logic                 shadow_screen
);

	zx_mem_pkg::model_t    model_q;
	logic [5:0]            page_7ffd;
	logic [2:0]            page_1ffd;
	logic                  io_wr;
	logic                  io_wr_q;
	logic                  io_wr_edge;
	logic                  is_plus3;
	logic                  locked;
	logic                  sel_7ffd;
	logic                  sel_1ffd;
	logic [1:0]            slot;
	logic                  special;
	logic [1:0]            special_mode;
	zx_mem_pkg::rom_bank_t rom_bank;
	zx_mem_pkg::ram_bank_t bank;
	logic                  rom_slot;

	// ========================================
	// Port decode
	// ========================================

	assign io_wr      = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_edge = io_wr & ~io_wr_q;

	assign is_plus3 = (model_q == zx_mem_pkg::MODEL_PLUS3);
	assign locked   = page_7ffd[5] | (model_q == zx_mem_pkg::MODEL_48);

	// Partial decode where A14 matters only on the +3
	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3) & ~locked;
	assign sel_1ffd = is_plus3 & ~bus.addr[1] & bus.addr[12] & ~bus.addr[13]
		& ~bus.addr[14] & ~bus.addr[15] & ~locked;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q   <= model;
			page_7ffd <= '0;
			page_1ffd <= '0;
			io_wr_q   <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			if (io_wr_edge) begin
				if (sel_7ffd)
					page_7ffd <= bus.dout[5:0];
				else if (sel_1ffd)
					page_1ffd <= bus.dout[2:0];
			end
		end
	end

	// ========================================
	// Address map
	// ========================================

	assign slot         = bus.addr[15:14];
	assign special      = page_1ffd[0];
	assign special_mode = page_1ffd[2:1];

	always_comb begin
		case (model_q)
			zx_mem_pkg::MODEL_128:   rom_bank = {1'b0, page_7ffd[4]};
			zx_mem_pkg::MODEL_PLUS3: rom_bank = {page_1ffd[2], page_7ffd[4]};
			default:                 rom_bank = '0;
		endcase
	end

	always_comb begin
		rom_slot = 1'b0;
		if (special) begin
			// All RAM with banks 0123, 4567, 4563 or 4763 for modes 00 to 11
			case (slot)
				2'd0:    bank = {|special_mode, 2'b00};
				2'd1:    bank = {|special_mode, &special_mode, 1'b1};
				2'd2:    bank = {|special_mode, 2'b10};
				default: bank = {~special_mode[1] & special_mode[0], 2'b11};
			endcase
		end else begin
			case (slot)
				2'd0: begin
					rom_slot = 1'b1;
					bank     = {1'b0, rom_bank};
				end
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				// Stays 0 on the 48K since 7FFD never leaves reset there
				default: bank = page_7ffd[2:0];
			endcase
		end
	end

	always_comb begin
		mem_req.addr.rom    = rom_slot;
		mem_req.addr.bank   = bank;
		mem_req.addr.offset = bus.addr[zx_mem_pkg::SLOT_OFS_W-1:0];
		mem_req.rd          = bus.mreq & bus.rd;
		mem_req.we          = bus.mreq & bus.wr & ~rom_slot;
		mem_req.wdata       = bus.dout;
	end

	assign shadow_screen = page_7ffd[3];

	// ========================================
	// Assertions
	// ========================================

	// Slot 0 outside special mode is ROM and never takes a write
	a_no_rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		(bus.addr[15:14] == 2'd0 && !page_1ffd[0]) |-> (mem_req.addr.rom && !mem_req.we));

	// Once locked, 7FFD holds until the next reset
	a_lock_holds: assert property (@(posedge clk_sys) disable iff (reset)
		locked |=> $stable(page_7ffd));

endmodule

/* design/ula_port.sv */
// ULA port FE: border, ear and mic outputs on write, and the read byte
// built from the keyboard half-row, joystick mask and tape input.

`timescale 1ns/1ps

module ula_port (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t bus,
	input  zx_bus_pkg::key_row_t keys,
	input  logic                 tape_in,
	input  zx_bus_pkg::key_row_t joy_mask,
	output zx_bus_pkg::data_t    fe_rdata,
	output logic [2:0]           border,
	output logic                 ear,
	output logic                 mic
);

	logic fe_wr;
	logic fe_wr_q;
	logic fe_wr_edge;

	// Any even port reaches the ULA
	assign fe_wr      = ~bus.addr[0] & bus.iorq & bus.wr & ~bus.m1;
	assign fe_wr_edge = fe_wr & ~fe_wr_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fe_wr_q <= 1'b0;
			border  <= '0;
			ear     <= 1'b0;
			mic     <= 1'b0;
		end else begin
			fe_wr_q <= fe_wr;
			if (fe_wr_edge) begin
				border <= bus.dout[2:0];
				mic    <= bus.dout[3];
				ear    <= bus.dout[4];
			end
		end
	end

	// Bits 7 and 5 float high on real hardware
	assign fe_rdata = {1'b1, ~tape_in, 1'b1, keys & joy_mask};

	// Outputs move only after reset or an FE write edge
	a_fe_source: assert property (@(posedge clk_sys)
		$changed({border, ear, mic}) |-> $past(fe_wr_edge || reset));

endmodule

/* design/zx_bus_glue.sv */
// Z80 side glue for a Spectrum 48K, 128K or +3.
// Decodes CPU bus cycles into banked memory requests, holds the paging
// and ULA port registers, and returns the CPU read byte.
// Every cycle completes without wait states.

`timescale 1ns/1ps

module zx_bus_glue (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_bus_pkg::cpu_bus_t   bus,
	input  zx_bus_pkg::data_t      mem_rdata,
	input  zx_mem_pkg::model_t     model,
	input  zx_bus_pkg::key_row_t   keys,
	input  logic                   tape_in,
	input  zx_bus_pkg::joy_state_t joy0,
	input  zx_bus_pkg::joy_state_t joy1,
	input  zx_bus_pkg::joy_mode_t  joy_mode,
	output zx_mem_pkg::mem_req_t   mem_req,
	output zx_bus_pkg::data_t      cpu_din,
	output logic [2:0]             border,
	output logic                   ear,
	output logic                   mic,
	output logic                   shadow_screen
);

	zx_bus_pkg::key_row_t joy_mask;
	zx_bus_pkg::data_t    kempston_data;
	zx_bus_pkg::data_t    fe_rdata;

	// ========================================
	// Memory paging
	// ========================================

	memory_pager pager0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (bus),
		.model         (model),
		.mem_req       (mem_req),
		.shadow_screen (shadow_screen)
	);

	// ========================================
	// Ports and read data
	// ========================================

	joystick_mapper joy0_map (
		.addr          (bus.addr),
		.joy0          (joy0),
		.joy1          (joy1),
		.joy_mode      (joy_mode),
		.joy_mask      (joy_mask),
		.kempston_data (kempston_data)
	);

	ula_port ula0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.keys     (keys),
		.tape_in  (tape_in),
		.joy_mask (joy_mask),
		.fe_rdata (fe_rdata),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	cpu_data_mux mux0 (
		.bus           (bus),
		.mem_rdata     (mem_rdata),
		.fe_rdata      (fe_rdata),
		.kempston_data (kempston_data),
		.cpu_din       (cpu_din)
	);

endmodule

/* design/zx_bus_pkg.sv */
// Z80 bus types shared by the Spectrum glue logic.
// Covers the CPU bus state, keyboard half-rows and joystick inputs.
// Modules refer to these by scoped name.

package zx_bus_pkg;

	// ========================================
	// CPU bus
	// ========================================

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;

	// One sampled bus state, strobes already active high
	typedef struct packed {
		addr_t addr;
		data_t dout;
		logic  mreq;
		logic  iorq;
		logic  rd;
		logic  wr;
		logic  m1;
	} cpu_bus_t;

	// ========================================
	// Keyboard and joysticks
	// ========================================

	// Five keys of one half-row, 0 when pressed
	typedef logic [4:0] key_row_t;

	// One joystick, 1 when pressed, bit 5 only reaches the Kempston port
	typedef logic [5:0] joy_state_t;

	// Bit positions inside joy_state_t
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	typedef enum logic [1:0] {
		JOY_KEMPSTON = 2'd0,
		JOY_SINCLAIR = 2'd1,
		JOY_CURSOR   = 2'd2
	} joy_mode_t;

endpackage

/* design/zx_mem_pkg.sv */
// Memory side types for the Spectrum glue logic.
// Describes the machine model, bank indices and the banked request
// that goes to external memory.

package zx_mem_pkg;

	// Offset width inside one 16 KB slot
	localparam int SLOT_OFS_W = 14;

	typedef enum logic [1:0] {
		MODEL_48    = 2'd0,
		MODEL_128   = 2'd1,
		MODEL_PLUS3 = 2'd2
	} model_t;

	// ========================================
	// Banks and addresses
	// ========================================

	typedef logic [2:0] ram_bank_t;
	typedef logic [1:0] rom_bank_t;

	// With rom set, the ROM bank sits in the low two bits of bank
	typedef struct packed {
		logic                  rom;
		ram_bank_t             bank;
		logic [SLOT_OFS_W-1:0] offset;
	} mem_addr_t;

	// ========================================
	// Requests
	// ========================================

	// One request per CPU memory cycle, no handshake back
	typedef struct packed {
		mem_addr_t         addr;
		logic              rd;
		logic              we;
		zx_bus_pkg::data_t wdata;
	} mem_req_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the zx_bus_glue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_zx_bus_glue \
	-Mdir obj_dir -o tb_zx_bus_glue -f zx_bus_glue.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_zx_bus_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verification/tb_zx_bus_glue.sv */
// Testbench for the Spectrum bus glue.
// Runs CPU bus cycles against each machine model; zx_glue_checks compares
// all DUT outputs with its reference model while the sequence runs.

`timescale 1ns/1ps

module tb_zx_bus_glue;

	// About 100 bus cycles of 5 clocks and three resets, wide margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic                   clk_sys;
	logic                   reset;
	zx_bus_pkg::cpu_bus_t   bus;
	zx_bus_pkg::data_t      mem_rdata;
	zx_mem_pkg::model_t     model;
	zx_bus_pkg::key_row_t   keys;
	logic                   tape_in;
	zx_bus_pkg::joy_state_t joy0;
	zx_bus_pkg::joy_state_t joy1;
	zx_bus_pkg::joy_mode_t  joy_mode;
	zx_mem_pkg::mem_req_t   mem_req;
	zx_bus_pkg::data_t      cpu_din;
	logic [2:0]             border;
	logic                   ear;
	logic                   mic;
	logic                   shadow_screen;
	int                     error_count;
	int                     seed = 32'h4e58ec02;
	int                     cycles = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;
	int                     errors_before = 0;

	zx_bus_glue dut0 (.*);

	zx_glue_checks checks0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic reset_dut(input zx_mem_pkg::model_t m);
		@(posedge clk_sys);
		reset <= 1'b1;
		model <= m;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// One bus cycle of four clocks, fresh random keys and joysticks with it
	task automatic run_cycle(input logic is_io, input logic is_wr,
			input zx_bus_pkg::addr_t a, input zx_bus_pkg::data_t d);
		zx_bus_pkg::cpu_bus_t b;
		logic [31:0]          rnd;
		b      = '0;
		b.addr = a;
		b.dout = d;
		b.mreq = ~is_io;
		b.iorq = is_io;
		b.rd   = ~is_wr;
		b.wr   = is_wr;
		rnd    = $random(seed);
		@(posedge clk_sys);
		bus       <= b;
		keys      <= rnd[4:0];
		tape_in   <= rnd[5];
		joy0      <= rnd[11:6];
		joy1      <= rnd[17:12];
		mem_rdata <= rnd[25:18];
		repeat (4) @(posedge clk_sys);
		bus <= '0;
	endtask

	// Key half-rows 4, 3, both and neither
	task automatic scan_rows(input zx_bus_pkg::joy_mode_t mode);
		@(posedge clk_sys);
		joy_mode <= mode;
		for (int i = 0; i < 4; i++) begin
			run_cycle(1'b1, 1'b0, 16'hEFFE, 8'h00);
			run_cycle(1'b1, 1'b0, 16'hF7FE, 8'h00);
			run_cycle(1'b1, 1'b0, 16'hE7FE, 8'h00);
			run_cycle(1'b1, 1'b0, 16'hFEFE, 8'h00);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		repeat (2) @(posedge clk_sys);
		if (error_count != errors_before) begin
			tests_failed++;
			$display("test %-14s failed, %0d mismatches", name, error_count - errors_before);
		end else begin
			$display("test %-14s passed", name);
		end
		errors_before = error_count;
	endtask

	initial begin
		reset     <= 1'b1;
		bus       <= '0;
		mem_rdata <= '0;
		model     <= zx_mem_pkg::MODEL_128;
		keys      <= '1;
		tape_in   <= 1'b0;
		joy0      <= '0;
		joy1      <= '0;
		joy_mode  <= zx_bus_pkg::JOY_KEMPSTON;

		reset_dut(zx_mem_pkg::MODEL_128);
		repeat (3) @(posedge clk_sys);
		run_cycle(1'b0, 1'b0, 16'hC000, 8'h00);
		finish_test("reset_state");

		// Bank 3, shadow screen, ROM 1
		run_cycle(1'b1, 1'b1, 16'h7FFD, 8'h1B);
		run_cycle(1'b0, 1'b0, 16'h0010, 8'h00);
		run_cycle(1'b0, 1'b0, 16'h4020, 8'h00);
		run_cycle(1'b0, 1'b1, 16'h8030, 8'hA5);
		run_cycle(1'b0, 1'b0, 16'hC040, 8'h00);
		run_cycle(1'b0, 1'b1, 16'h1234, 8'h5A);
		run_cycle(1'b1, 1'b1, 16'h7FFD, 8'h26);
		run_cycle(1'b1, 1'b1, 16'h7FFD, 8'h01);
		run_cycle(1'b0, 1'b1, 16'hC100, 8'h3C);
		finish_test("paging_128k");

		reset_dut(zx_mem_pkg::MODEL_PLUS3);
		for (int m = 0; m < 4; m++) begin
			run_cycle(1'b1, 1'b1, 16'h1FFD, 8'(m * 2 + 1));
			for (int s = 0; s < 4; s++)
				run_cycle(1'b0, s[0], 16'(s * 16'h4000 + 16'h0123), 8'(m));
		end
		run_cycle(1'b1, 1'b1, 16'h1FFD, 8'h04);
		run_cycle(1'b1, 1'b1, 16'h7FFD, 8'h10);
		run_cycle(1'b0, 1'b0, 16'h0100, 8'h00);
		run_cycle(1'b0, 1'b1, 16'h0200, 8'h55);
		finish_test("paging_plus3");

		reset_dut(zx_mem_pkg::MODEL_48);
		run_cycle(1'b1, 1'b1, 16'h7FFD, 8'h0F);
		run_cycle(1'b0, 1'b0, 16'hC000, 8'h00);
		finish_test("paging_48k");

		run_cycle(1'b1, 1'b1, 16'h00FE, 8'h1D);
		run_cycle(1'b1, 1'b1, 16'h12FE, 8'h0A);
		for (int i = 0; i < 8; i++)
			run_cycle(1'b1, 1'b0, {8'(i * 37), 8'hFE}, 8'h00);
		finish_test("port_fe");

		scan_rows(zx_bus_pkg::JOY_SINCLAIR);
		scan_rows(zx_bus_pkg::JOY_CURSOR);
		@(posedge clk_sys);
		joy_mode <= zx_bus_pkg::JOY_KEMPSTON;
		for (int i = 0; i < 4; i++)
			run_cycle(1'b1, 1'b0, 16'h001F, 8'h00);
		run_cycle(1'b1, 1'b0, 16'h00FF, 8'h00);
		run_cycle(1'b0, 1'b0, 16'h9ABC, 8'h00);
		finish_test("joystick_data");

		$display("tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* verification/zx_glue_checks.sv */
// Reference model and output checks for the Spectrum bus glue.
// Tracks paging, lock and port FE from the DUT port activity and compares
// every DUT output on the falling clock edge, half a cycle after inputs move.
// error_count is the running total of mismatches.

`timescale 1ns/1ps

module zx_glue_checks (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_bus_pkg::cpu_bus_t   bus,
	input  zx_bus_pkg::data_t      mem_rdata,
	input  zx_mem_pkg::model_t     model,
	input  zx_bus_pkg::key_row_t   keys,
	input  logic                   tape_in,
	input  zx_bus_pkg::joy_state_t joy0,
	input  zx_bus_pkg::joy_state_t joy1,
	input  zx_bus_pkg::joy_mode_t  joy_mode,
	input  zx_mem_pkg::mem_req_t   mem_req,
	input  zx_bus_pkg::data_t      cpu_din,
	input  logic [2:0]             border,
	input  logic                   ear,
	input  logic                   mic,
	input  logic                   shadow_screen,
	output int                     error_count
);

	zx_mem_pkg::model_t     ref_model;
	zx_bus_pkg::data_t      ref_7ffd;
	logic [2:0]             ref_1ffd;
	logic [4:0]             ref_fe;
	logic                   wr_prev;
	logic                   wr_now;
	logic                   io_rd;
	logic                   locked;
	logic [11:0]            slot_banks;
	zx_mem_pkg::mem_req_t   exp_req;
	zx_bus_pkg::joy_state_t joy_or;
	zx_bus_pkg::key_row_t   held_60;
	zx_bus_pkg::key_row_t   held_15;
	zx_bus_pkg::data_t      exp_din;
	int                     err_req = 0;
	int                     err_din = 0;
	int                     err_fe = 0;
	int                     err_shadow = 0;

	// ========================================
	// Register shadow
	// ========================================

	assign wr_now = bus.iorq & bus.wr & ~bus.m1;
	assign io_rd  = bus.iorq & bus.rd & ~bus.m1;
	assign locked = ref_7ffd[5] | (ref_model == zx_mem_pkg::MODEL_48);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ref_model <= model;
			ref_7ffd  <= '0;
			ref_1ffd  <= '0;
			ref_fe    <= '0;
			wr_prev   <= 1'b0;
		end else begin
			wr_prev <= wr_now;
			if (wr_now && !wr_prev) begin
				if (!locked && !bus.addr[15] && !bus.addr[1]
						&& (bus.addr[14] || ref_model != zx_mem_pkg::MODEL_PLUS3))
					ref_7ffd <= bus.dout;
				if (!locked && ref_model == zx_mem_pkg::MODEL_PLUS3 && !bus.addr[1]
						&& bus.addr[15:12] == 4'b0001)
					ref_1ffd <= bus.dout[2:0];
				// Bits 2:0 border, bit 3 mic, bit 4 ear
				if (!bus.addr[0])
					ref_fe <= bus.dout[4:0];
			end
		end
	end

	// ========================================
	// Expected outputs
	// ========================================

	always_comb begin
		// Special mode banks, slot 0 in the low three bits
		case (ref_1ffd[2:1])
			2'd0:    slot_banks = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    slot_banks = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    slot_banks = {3'd3, 3'd6, 3'd5, 3'd4};
			default: slot_banks = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		exp_req.addr.offset = bus.addr[13:0];
		exp_req.addr.rom    = 1'b0;
		if (ref_1ffd[0]) begin
			exp_req.addr.bank = slot_banks[3 * bus.addr[15:14] +: 3];
		end else if (bus.addr[15:14] == 2'd0) begin
			exp_req.addr.rom = 1'b1;
			case (ref_model)
				zx_mem_pkg::MODEL_128:   exp_req.addr.bank = {2'b00, ref_7ffd[4]};
				zx_mem_pkg::MODEL_PLUS3: exp_req.addr.bank = {1'b0, ref_1ffd[2], ref_7ffd[4]};
				default:                 exp_req.addr.bank = 3'd0;
			endcase
		end else if (bus.addr[15:14] == 2'd1) begin
			exp_req.addr.bank = 3'd5;
		end else if (bus.addr[15:14] == 2'd2) begin
			exp_req.addr.bank = 3'd2;
		end else begin
			exp_req.addr.bank = ref_7ffd[2:0];
		end
		exp_req.rd    = bus.mreq & bus.rd;
		exp_req.we    = bus.mreq & bus.wr & ~exp_req.addr.rom;
		exp_req.wdata = bus.dout;
	end

	// Joystick bits: 0 right, 1 left, 2 down, 3 up, 4 fire
	always_comb begin
		joy_or  = joy0 | joy1;
		held_60 = '0;
		held_15 = '0;
		if (joy_mode == zx_bus_pkg::JOY_SINCLAIR) begin
			held_60 = {joy0[1], joy0[0], joy0[2], joy0[3], joy0[4]};
			held_15 = {joy1[4], joy1[3], joy1[2], joy1[0], joy1[1]};
		end else if (joy_mode == zx_bus_pkg::JOY_CURSOR) begin
			held_60 = {joy_or[2], joy_or[3], joy_or[0], 1'b0, joy_or[4]};
			held_15 = {joy_or[1], 4'b0000};
		end
		if (bus.mreq && bus.rd)
			exp_din = mem_rdata;
		else if (io_rd && !bus.addr[0])
			exp_din = {1'b1, ~tape_in, 1'b1, keys & ~((bus.addr[12] ? 5'b0 : held_60)
				| (bus.addr[11] ? 5'b0 : held_15))};
		else if (io_rd && bus.addr[7:0] == 8'h1F)
			exp_din = (joy_mode == zx_bus_pkg::JOY_KEMPSTON) ? {2'b00, joy_or} : 8'h00;
		else
			exp_din = 8'hFF;
	end

	// ========================================
	// Checks
	// ========================================

	a_mem_req: assert property (@(negedge clk_sys) disable iff (reset) mem_req == exp_req)
		else begin
			$display("[FAIL] %0t mem_req expected %h actual %h", $time, exp_req, mem_req);
			err_req++;
		end

	a_cpu_din: assert property (@(negedge clk_sys) disable iff (reset) cpu_din == exp_din)
		else begin
			$display("[FAIL] %0t cpu_din expected %h actual %h", $time, exp_din, cpu_din);
			err_din++;
		end

	a_fe_out: assert property (@(negedge clk_sys) disable iff (reset)
		{border, ear, mic} == {ref_fe[2:0], ref_fe[4], ref_fe[3]})
		else begin
			$display("[FAIL] %0t {border,ear,mic} expected %b actual %b", $time,
				{ref_fe[2:0], ref_fe[4], ref_fe[3]}, {border, ear, mic});
			err_fe++;
		end

	a_shadow: assert property (@(negedge clk_sys) disable iff (reset)
		shadow_screen == ref_7ffd[3])
		else begin
			$display("[FAIL] %0t shadow_screen expected %b actual %b", $time,
				ref_7ffd[3], shadow_screen);
			err_shadow++;
		end

	assign error_count = err_req + err_din + err_fe + err_shadow;

endmodule

/* zx_bus_glue.f */
design/zx_bus_pkg.sv
design/zx_mem_pkg.sv
design/memory_pager.sv
design/ula_port.sv
design/joystick_mapper.sv
design/cpu_data_mux.sv
design/zx_bus_glue.sv
verification/zx_glue_checks.sv
verification/tb_zx_bus_glue.sv
